/* sim.f */
design/backend_pkg.sv
design/gpr.sv
design/dispatch.sv
design/alu.sv
design/mul_pipe.sv
design/wbu.sv
design/exu_backend.sv
test/exu_backend_assertions.sv
test/tb_exu_backend.sv

/* run_sim.sh */
#!/bin/sh
# build and run the exu_backend testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_exu_backend \
    -o sim_exu_backend \
    && ./obj_dir/sim_exu_backend > sim.log 2>&1 \
    || echo "build or simulation run failed"
grep -q "NO ERRORS" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* test/tb_exu_backend.sv */
`timescale 1ns/1ps
/*
 table-driven testbench for exu_backend, expected values come from a shadow register model
 writes are matched per destination register, so ordering is only checked within one rd
*/
module tb_exu_backend;

    localparam int          CLK_HALF     = 4;
    localparam int          RESET_CYCLES = 5;
    localparam logic [15:0] LFSR_SEED    = 16'd29;

    typedef struct packed {
        backend_pkg::issue_op_t op;
        backend_pkg::wb_t       exp;  // write the op must produce
    } row_t;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   issue_valid;
    backend_pkg::issue_op_t issue_op;
    logic                   stall;
    backend_pkg::wb_t       wb;

    row_t                         rows [$];
    logic [backend_pkg::XLEN-1:0] shadow [backend_pkg::NUM_GPR];
    backend_pkg::wb_t             exp_q [backend_pkg::NUM_GPR][$];
    logic [15:0]                  lfsr_q = LFSR_SEED;
    logic                         saw_stall = 1'b0;
    int                           pushed = 0;
    int                           popped = 0;
    int                           value_errors = 0;
    int                           order_errors = 0;

    exu_backend dut_i (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .issue_valid_i(issue_valid),
        .issue_op_i   (issue_op),
        .stall_o      (stall),
        .wb_o         (wb)
    );

    always #CLK_HALF clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_step()};
        end
        return w;
    endfunction

    function automatic logic [31:0] alu_ref(input backend_pkg::alu_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] fill;
        sh   = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;  // sign bits shifted in by sra
        case (op)
            backend_pkg::ALU_ADD:  return a + b;
            backend_pkg::ALU_SUB:  return a - b;
            backend_pkg::ALU_SLL:  return a << sh;
            backend_pkg::ALU_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            backend_pkg::ALU_SLTU: return {31'b0, a < b};
            backend_pkg::ALU_XOR:  return a ^ b;
            backend_pkg::ALU_SRL:  return a >> sh;
            backend_pkg::ALU_SRA:  return (a >> sh) | fill;
            backend_pkg::ALU_OR:   return a | b;
            backend_pkg::ALU_AND:  return a & b;
            default:               return 32'h0;
        endcase
    endfunction

    // 64-bit product of the extended operands, mod 2^64 is exact here
    function automatic logic [31:0] mul_ref(input backend_pkg::mul_var_e v,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [63:0] ax;
        logic [63:0] bx;
        logic [63:0] p;
        ax = {((v == backend_pkg::MUL_MULH || v == backend_pkg::MUL_MULHSU) && a[31]) ?
              32'hffff_ffff : 32'h0, a};
        bx = {(v == backend_pkg::MUL_MULH && b[31]) ? 32'hffff_ffff : 32'h0, b};
        p  = ax * bx;
        return (v == backend_pkg::MUL_MUL) ? p[31:0] : p[63:32];
    endfunction

    // program order model, hazard stalls make issue order match it
    task automatic push_row(input backend_pkg::issue_op_t op);
        row_t        row;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        a      = shadow[op.rs1];
        b      = op.use_imm ? op.imm : shadow[op.rs2];
        row.op = op;
        if (op.grp == backend_pkg::GRP_MUL) begin
            val = mul_ref(op.op.mul.variant, a, b);
        end else begin
            val = alu_ref(op.op.alu, a, b);
        end
        row.exp.valid = (op.rd != '0);  // x0 results never reach the port
        row.exp.waddr = op.rd;
        row.exp.wdata = val;
        if (op.rd != '0) begin
            shadow[op.rd] = val;
        end
        rows.push_back(row);
    endtask

    task automatic alu_row(input backend_pkg::alu_op_e op, input int rd, input int rs1,
                           input int rs2, input logic use_imm, input logic [31:0] imm);
        backend_pkg::issue_op_t o;
        o.grp     = backend_pkg::GRP_ALU;
        o.op.alu  = op;
        o.rd      = backend_pkg::REG_ADDR_W'(rd);
        o.rs1     = backend_pkg::REG_ADDR_W'(rs1);
        o.rs2     = backend_pkg::REG_ADDR_W'(rs2);
        o.use_imm = use_imm;
        o.imm     = imm;
        push_row(o);
    endtask

    task automatic mul_row(input backend_pkg::mul_var_e v, input int rd, input int rs1,
                           input int rs2);
        backend_pkg::issue_op_t o;
        o.grp            = backend_pkg::GRP_MUL;
        o.op.mul.rsvd    = '0;
        o.op.mul.variant = v;
        o.rd             = backend_pkg::REG_ADDR_W'(rd);
        o.rs1            = backend_pkg::REG_ADDR_W'(rs1);
        o.rs2            = backend_pkg::REG_ADDR_W'(rs2);
        o.use_imm        = 1'b0;
        o.imm            = '0;
        push_row(o);
    endtask

    task automatic build_table();
        for (int i = 0; i < backend_pkg::NUM_GPR; i++) begin
            shadow[i] = '0;
        end
        alu_row(backend_pkg::ALU_ADD,  1, 0, 0, 1'b1, 32'h8000_0000);  // extremes
        alu_row(backend_pkg::ALU_ADD,  2, 0, 0, 1'b1, 32'h7fff_ffff);
        alu_row(backend_pkg::ALU_ADD,  3, 0, 0, 1'b1, 32'hffff_ffff);
        alu_row(backend_pkg::ALU_ADD,  4, 0, 0, 1'b1, rand_word());
        alu_row(backend_pkg::ALU_ADD,  5, 4, 2, 1'b0, 32'h0);
        alu_row(backend_pkg::ALU_SUB,  6, 4, 1, 1'b0, 32'h0);
        alu_row(backend_pkg::ALU_SLL,  7, 3, 0, 1'b1, 32'd7);
        alu_row(backend_pkg::ALU_SLT,  8, 1, 2, 1'b0, 32'h0);
        alu_row(backend_pkg::ALU_SLTU, 9, 1, 2, 1'b0, 32'h0);
        alu_row(backend_pkg::ALU_XOR, 10, 4, 0, 1'b1, rand_word());
        alu_row(backend_pkg::ALU_SRL, 11, 1, 4, 1'b0, 32'h0);     // shift amount from rs2
        alu_row(backend_pkg::ALU_SRA, 12, 1, 0, 1'b1, 32'd3);
        alu_row(backend_pkg::ALU_OR,  13, 4, 5, 1'b0, 32'h0);
        alu_row(backend_pkg::ALU_AND, 14, 4, 0, 1'b1, rand_word());
        mul_row(backend_pkg::MUL_MUL,    20, 1, 3);
        mul_row(backend_pkg::MUL_MULH,   21, 1, 1);
        mul_row(backend_pkg::MUL_MULHSU, 22, 1, 3);
        mul_row(backend_pkg::MUL_MULHU,  23, 3, 3);
        mul_row(backend_pkg::MUL_MULH,   24, 4, 2);  // scoreboard fills up here
        alu_row(backend_pkg::ALU_ADD, 25, 24, 0, 1'b1, 32'd1);  // waits for the multiply
        alu_row(backend_pkg::ALU_ADD, 26, 0, 0, 1'b1, 32'd5);
        alu_row(backend_pkg::ALU_ADD, 26, 26, 4, 1'b0, 32'h0);  // same rd back to back
        mul_row(backend_pkg::MUL_MUL, 27, 2, 2);
        alu_row(backend_pkg::ALU_ADD,  0, 4, 3, 1'b0, 32'h0);   // x0 filler, no write
        alu_row(backend_pkg::ALU_ADD, 28, 0, 0, 1'b1, 32'd3);   // lands with the mul
        mul_row(backend_pkg::MUL_MULHU, 0, 3, 3);
        alu_row(backend_pkg::ALU_SUB, 29, 28, 27, 1'b0, 32'h0);
    endtask

    task automatic check_wb(input backend_pkg::wb_t got, input backend_pkg::wb_t exp,
                            input string what);
        if (got.valid !== exp.valid ||
            (exp.valid && (got.waddr !== exp.waddr || got.wdata !== exp.wdata))) begin
            value_errors++;
            $display("ERROR %0t: %s, got valid %b x%0d %h, expected valid %b x%0d %h", $time,
                     what, got.valid, got.waddr, got.wdata, exp.valid, exp.waddr, exp.wdata);
        end
    endtask

    task automatic check_stall(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %0t: %s, stall got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic watch_writes();
        backend_pkg::wb_t exp_wb;
        forever begin
            @(negedge clk);
            if (wb.valid) begin
                if (exp_q[wb.waddr].size() == 0) begin
                    order_errors++;
                    $display("unexpected write to x%0d at %0t, no result was pending for it",
                             wb.waddr, $time);
                end else begin
                    exp_wb = exp_q[wb.waddr].pop_front();
                    popped++;
                    check_wb(wb, exp_wb, "writeback");
                end
            end
        end
    endtask

    task automatic report_and_finish();
        int assert_errors;
        for (int i = 0; i < backend_pkg::NUM_GPR; i++) begin
            if (exp_q[i].size() != 0) begin
                order_errors += exp_q[i].size();
                $display("x%0d never received %0d expected writes", i, exp_q[i].size());
            end
        end
        assert_errors = dut_i.u_assertions.x0_fails + dut_i.u_assertions.reset_fails +
                        dut_i.u_assertions.xdata_fails;
        $display("errors: %0d value, %0d write order, %0d assertion",
                 value_errors, order_errors, assert_errors);
        if (value_errors == 0 && order_errors == 0 && assert_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    initial begin
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_op    = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        fork
            watch_writes();
        join_none
        repeat (4) begin  // nothing issued, so no stall and no write
            @(negedge clk);
            check_stall(stall, 1'b0, "idle after reset");
            check_wb(wb, '0, "idle after reset");
        end
        for (int r = 0; r < rows.size(); r++) begin
            @(posedge clk);
            issue_valid <= 1'b1;
            issue_op    <= rows[r].op;
            @(negedge clk);
            while (stall) begin  // op held until dispatch takes it
                saw_stall = 1'b1;
                @(negedge clk);
            end
            if (rows[r].op.rd != '0) begin
                exp_q[rows[r].op.rd].push_back(rows[r].exp);
                pushed++;
            end
        end
        @(posedge clk);
        issue_valid <= 1'b0;
        while (popped != pushed) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);  // room for any stray write
        check_stall(saw_stall, 1'b1, "stall seen during the run");
        report_and_finish();
    end

    initial begin
        wait (rst_n === 1'b1);
        repeat (rows.size() * 8 + 50) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", rows.size() * 8 + 50);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* test/exu_backend_assertions.sv */
`timescale 1ns/1ps
/*
 concurrent checks on the writeback port, bound into exu_backend
 the fail counters are read by the testbench at the end of the run
*/
module exu_backend_assertions (
    input logic             clk_i,
    input logic             rst_n_i,
    input logic             stall_i,
    input backend_pkg::wb_t wb_i
);

    int x0_fails    = 0;
    int reset_fails = 0;
    int xdata_fails = 0;

    // arbiter drops every x0 result
    no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_i.valid |-> wb_i.waddr != '0)
        else begin
            x0_fails++;
            $error("write port active with waddr x0");
        end

    reset_quiet: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !stall_i && !wb_i.valid)
        else begin
            reset_fails++;
            $error("stall or write active in the first cycle after reset");
        end

    wdata_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_i.valid |-> !$isunknown(wb_i.wdata))
        else begin
            xdata_fails++;
            $error("write data unknown while the write is valid");
        end

endmodule

bind exu_backend exu_backend_assertions u_assertions (
    .clk_i  (clk),
    .rst_n_i(rst_n_i),
    .stall_i(stall_o),
    .wb_i   (wb_o)
);

/* design/exu_backend.sv */
`timescale 1ns/1ps
/*
 execute and writeback back end: dispatch, alu, multiplier, arbiter, register file
 issue_op_i must stay stable while stall_o is high
*/
module exu_backend (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   issue_valid_i,
    input  backend_pkg::issue_op_t issue_op_i,
    output logic                   stall_o,
    output backend_pkg::wb_t       wb_o
);

    logic [backend_pkg::REG_ADDR_W-1:0]  rs1_addr;
    logic [backend_pkg::REG_ADDR_W-1:0]  rs2_addr;
    logic [backend_pkg::XLEN-1:0]        rs1_rdata;
    logic [backend_pkg::XLEN-1:0]        rs2_rdata;
    backend_pkg::exec_req_t              alu_req;
    backend_pkg::exec_req_t              mul_req;
    backend_pkg::unit_res_t              alu_res;
    backend_pkg::unit_res_t              mul_res;
    logic                                alu_ready;
    logic                                commit_valid;
    logic [backend_pkg::COMMIT_ID_W-1:0] commit_id;

    dispatch u_dispatch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_op_i    (issue_op_i),
        .rs1_rdata_i   (rs1_rdata),
        .rs2_rdata_i   (rs2_rdata),
        .alu_ready_i   (alu_ready),
        .commit_valid_i(commit_valid),
        .commit_id_i   (commit_id),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .alu_req_o     (alu_req),
        .mul_req_o     (mul_req),
        .stall_o       (stall_o)
    );

    gpr u_gpr (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_i    (wb_o),
        .raddr1_i(rs1_addr),
        .raddr2_i(rs2_addr),
        .rdata1_o(rs1_rdata),
        .rdata2_o(rs2_rdata)
    );

    alu u_alu (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .req_i  (alu_req),
        .ready_i(alu_ready),
        .res_o  (alu_res)
    );

    mul_pipe u_mul_pipe (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .req_i  (mul_req),
        .res_o  (mul_res)
    );

    wbu u_wbu (
        .alu_res_i     (alu_res),
        .mul_res_i     (mul_res),
        .alu_ready_o   (alu_ready),
        .wb_o          (wb_o),
        .commit_valid_o(commit_valid),
        .commit_id_o   (commit_id)
    );

endmodule

/* design/wbu.sv */
`timescale 1ns/1ps
/*
 combinational writeback arbiter, the multiplier always wins
 the losing alu result is held by the alu via alu_ready_o
*/
module wbu (
    input  backend_pkg::unit_res_t               alu_res_i,
    input  backend_pkg::unit_res_t               mul_res_i,
    output logic                                 alu_ready_o,
    output backend_pkg::wb_t                     wb_o,
    output logic                                 commit_valid_o,
    output logic [backend_pkg::COMMIT_ID_W-1:0]  commit_id_o
);

    backend_pkg::unit_res_t win;
    logic                   win_writes;

    assign win        = mul_res_i.valid ? mul_res_i : alu_res_i;
    assign win_writes = win.valid && (win.rd != '0);  // x0 ops end here

    // conflict stalls the alu one cycle
    assign alu_ready_o = !(mul_res_i.valid && alu_res_i.valid);

    always_comb begin
        wb_o.valid = win_writes;
        wb_o.waddr = win.rd;
        wb_o.wdata = win.data;
    end

    // frees the scoreboard entry at the same edge as the gpr write
    assign commit_valid_o = win_writes;
    assign commit_id_o    = win.commit_id;

endmodule

/* design/mul_pipe.sv */
`timescale 1ns/1ps
/*
 three stage multiplier: extend, multiply, pick word; cannot be stalled
 datapath is written for MUL_STAGES == 3, the tag pipe follows MUL_STAGES
*/
module mul_pipe (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  backend_pkg::exec_req_t req_i,
    output backend_pkg::unit_res_t res_o
);

    backend_pkg::mul_var_e                mvar;
    logic                                 a_signed;
    logic                                 b_signed;
    logic signed [backend_pkg::XLEN:0]    s1_a_q;  // one extra bit carries sign or zero
    logic signed [backend_pkg::XLEN:0]    s1_b_q;
    backend_pkg::mul_var_e                s1_var_q;
    logic signed [2*backend_pkg::XLEN+1:0] s2_prod_q;
    backend_pkg::mul_var_e                s2_var_q;
    logic [backend_pkg::XLEN-1:0]         s3_data_q;
    logic [backend_pkg::MUL_STAGES-1:0]   vld_q;
    logic [backend_pkg::REG_ADDR_W-1:0]   rd_q  [backend_pkg::MUL_STAGES];
    logic [backend_pkg::COMMIT_ID_W-1:0]  cid_q [backend_pkg::MUL_STAGES];

    assign mvar     = req_i.op.mul.variant;
    assign a_signed = (mvar == backend_pkg::MUL_MULH) || (mvar == backend_pkg::MUL_MULHSU);
    assign b_signed = (mvar == backend_pkg::MUL_MULH);

    // tag pipe, valid only under reset
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[backend_pkg::MUL_STAGES-2:0], req_i.valid};
        end
    end

    always_ff @(posedge clk) begin
        rd_q[0]  <= req_i.rd;
        cid_q[0] <= req_i.commit_id;
        for (int i = 1; i < backend_pkg::MUL_STAGES; i++) begin
            rd_q[i]  <= rd_q[i-1];
            cid_q[i] <= cid_q[i-1];
        end
    end

    // stage 1 extend
    always_ff @(posedge clk) begin
        s1_a_q   <= {a_signed & req_i.op_a[backend_pkg::XLEN-1], req_i.op_a};
        s1_b_q   <= {b_signed & req_i.op_b[backend_pkg::XLEN-1], req_i.op_b};
        s1_var_q <= mvar;
    end

    // stage 2 full signed product
    always_ff @(posedge clk) begin
        s2_prod_q <= s1_a_q * s1_b_q;
        s2_var_q  <= s1_var_q;
    end

    // stage 3 word select
    always_ff @(posedge clk) begin
        if (s2_var_q == backend_pkg::MUL_MUL) begin
            s3_data_q <= s2_prod_q[backend_pkg::XLEN-1:0];
        end else begin
            s3_data_q <= s2_prod_q[2*backend_pkg::XLEN-1:backend_pkg::XLEN];
        end
    end

    always_comb begin
        res_o.valid     = vld_q[backend_pkg::MUL_STAGES-1];
        res_o.rd        = rd_q[backend_pkg::MUL_STAGES-1];
        res_o.data      = s3_data_q;
        res_o.commit_id = cid_q[backend_pkg::MUL_STAGES-1];
    end

endmodule

/* design/alu.sv */
`timescale 1ns/1ps
/*
 single cycle integer alu with a registered result
 result and tag are held while ready_i is low; the request must be held upstream too
*/
module alu (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  backend_pkg::exec_req_t req_i,
    input  logic                   ready_i,
    output backend_pkg::unit_res_t res_o
);

    logic [backend_pkg::XLEN-1:0]        a;
    logic [backend_pkg::XLEN-1:0]        b;
    logic [backend_pkg::SHAMT_W-1:0]     shamt;
    logic [backend_pkg::XLEN-1:0]        result;
    logic                                res_valid_q;
    logic [backend_pkg::REG_ADDR_W-1:0]  res_rd_q;
    logic [backend_pkg::XLEN-1:0]        res_data_q;
    logic [backend_pkg::COMMIT_ID_W-1:0] res_cid_q;

    assign a     = req_i.op_a;
    assign b     = req_i.op_b;
    assign shamt = b[backend_pkg::SHAMT_W-1:0];

    always_comb begin
        case (req_i.op.alu)
            backend_pkg::ALU_ADD:  result = a + b;
            backend_pkg::ALU_SUB:  result = a - b;
            backend_pkg::ALU_SLL:  result = a << shamt;
            backend_pkg::ALU_SLT:  result = {{(backend_pkg::XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            backend_pkg::ALU_SLTU: result = {{(backend_pkg::XLEN-1){1'b0}}, a < b};
            backend_pkg::ALU_XOR:  result = a ^ b;
            backend_pkg::ALU_SRL:  result = a >> shamt;
            backend_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            backend_pkg::ALU_OR:   result = a | b;
            backend_pkg::ALU_AND:  result = a & b;
            default:               result = '0;  // unused encodings
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (ready_i) begin
            res_valid_q <= req_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ready_i) begin
            res_rd_q   <= req_i.rd;
            res_data_q <= result;
            res_cid_q  <= req_i.commit_id;
        end
    end

    always_comb begin
        res_o.valid     = res_valid_q;
        res_o.rd        = res_rd_q;
        res_o.data      = res_data_q;
        res_o.commit_id = res_cid_q;
    end

endmodule

/* design/dispatch.sv */
`timescale 1ns/1ps
/*
 hazard check, commit id allocation and one pipe register per unit
 ops with rd == x0 take no scoreboard entry; a held alu request blocks new issue
*/
module dispatch (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                issue_valid_i,
    input  backend_pkg::issue_op_t              issue_op_i,
    input  logic [backend_pkg::XLEN-1:0]        rs1_rdata_i,
    input  logic [backend_pkg::XLEN-1:0]        rs2_rdata_i,
    input  logic                                alu_ready_i,
    input  logic                                commit_valid_i,
    input  logic [backend_pkg::COMMIT_ID_W-1:0] commit_id_i,
    output logic [backend_pkg::REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [backend_pkg::REG_ADDR_W-1:0]  rs2_addr_o,
    output backend_pkg::exec_req_t              alu_req_o,
    output backend_pkg::exec_req_t              mul_req_o,
    output logic                                stall_o
);

    logic [backend_pkg::SB_DEPTH-1:0]    sb_valid_q;
    logic [backend_pkg::REG_ADDR_W-1:0]  sb_rd_q [backend_pkg::SB_DEPTH];
    logic                                sb_hit;
    logic                                sb_full;
    logic [backend_pkg::COMMIT_ID_W-1:0] alloc_id;
    logic                                accept;
    logic                                writes_rd;
    backend_pkg::exec_req_t              req_d;
    backend_pkg::exec_req_t              alu_req_q;
    backend_pkg::exec_req_t              mul_req_q;

    assign rs1_addr_o = issue_op_i.rs1;  // gpr read is combinational
    assign rs2_addr_o = issue_op_i.rs2;

    // match against every pending destination
    always_comb begin
        sb_hit = 1'b0;
        for (int i = 0; i < backend_pkg::SB_DEPTH; i++) begin
            if (sb_valid_q[i] &&
                (sb_rd_q[i] == issue_op_i.rs1 ||
                 (!issue_op_i.use_imm && sb_rd_q[i] == issue_op_i.rs2) ||
                 sb_rd_q[i] == issue_op_i.rd)) begin
                sb_hit = 1'b1;
            end
        end
    end

    // lowest free entry wins
    always_comb begin
        alloc_id = '0;
        for (int i = backend_pkg::SB_DEPTH - 1; i >= 0; i--) begin
            if (!sb_valid_q[i]) begin
                alloc_id = backend_pkg::COMMIT_ID_W'(i);
            end
        end
    end

    assign sb_full   = &sb_valid_q;
    assign stall_o   = issue_valid_i && (sb_hit || sb_full || !alu_ready_i);
    assign accept    = issue_valid_i && !stall_o;
    assign writes_rd = (issue_op_i.rd != '0);

    // commit frees, issue allocates; never the same entry in one cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sb_valid_q <= '0;
        end else begin
            if (commit_valid_i) begin
                sb_valid_q[commit_id_i] <= 1'b0;
            end
            if (accept && writes_rd) begin
                sb_valid_q[alloc_id] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && writes_rd) begin
            sb_rd_q[alloc_id] <= issue_op_i.rd;
        end
    end

    always_comb begin
        req_d.valid     = 1'b1;
        req_d.op        = issue_op_i.op;
        req_d.op_a      = rs1_rdata_i;
        req_d.op_b      = issue_op_i.use_imm ? issue_op_i.imm : rs2_rdata_i;
        req_d.rd        = issue_op_i.rd;
        req_d.commit_id = alloc_id;
    end

    // alu request stays put while the alu result is held
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            alu_req_q.valid <= 1'b0;
            mul_req_q.valid <= 1'b0;
        end else begin
            if (accept && issue_op_i.grp == backend_pkg::GRP_ALU) begin
                alu_req_q <= req_d;
            end else if (alu_ready_i) begin
                alu_req_q.valid <= 1'b0;
            end
            if (accept && issue_op_i.grp == backend_pkg::GRP_MUL) begin
                mul_req_q <= req_d;
            end else begin
                mul_req_q.valid <= 1'b0;  // multiplier never waits
            end
        end
    end

    assign alu_req_o = alu_req_q;
    assign mul_req_o = mul_req_q;

endmodule

/* design/gpr.sv */
`timescale 1ns/1ps
/*
 32 general registers, async read, write on the clock edge
 a write is visible on the read ports only after the edge
*/
module gpr (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  backend_pkg::wb_t                   wb_i,
    input  logic [backend_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [backend_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [backend_pkg::XLEN-1:0]       rdata1_o,
    output logic [backend_pkg::XLEN-1:0]       rdata2_o
);

    logic [backend_pkg::XLEN-1:0] regs_q [backend_pkg::NUM_GPR];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < backend_pkg::NUM_GPR; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.waddr != '0) begin
            regs_q[wb_i.waddr] <= wb_i.wdata;
        end
    end

    // x0 is hardwired
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

/* design/backend_pkg.sv */
/*
 widths, op encodings and the request and result structs of the execute back end
 the two upper bits of mul_op_t are reserved and should be driven as zero
*/
package backend_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_GPR     = 1 << REG_ADDR_W;
    localparam int SHAMT_W     = $clog2(XLEN);
    localparam int COMMIT_ID_W = 2;
    localparam int SB_DEPTH    = 1 << COMMIT_ID_W;  // one scoreboard entry per commit id
    localparam int MUL_STAGES  = 3;

    // functional unit that takes the op
    typedef enum logic {
        GRP_ALU = 1'b0,
        GRP_MUL = 1'b1
    } op_grp_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        MUL_MUL    = 2'd0,  // low word
        MUL_MULH   = 2'd1,  // signed x signed, high word
        MUL_MULHSU = 2'd2,  // signed x unsigned
        MUL_MULHU  = 2'd3
    } mul_var_e;

    typedef struct packed {
        logic [1:0] rsvd;
        mul_var_e   variant;
    } mul_op_t;

    // op field, read as alu or mul view depending on op_grp_e
    typedef union packed {
        alu_op_e alu;
        mul_op_t mul;
    } op_info_u;

    typedef struct packed {
        op_grp_e                grp;
        op_info_u               op;
        logic [REG_ADDR_W-1:0]  rd;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [REG_ADDR_W-1:0]  rs2;
        logic                   use_imm;  // operand 2 from imm instead of rs2
        logic [XLEN-1:0]        imm;
    } issue_op_t;

    typedef struct packed {
        logic                   valid;
        op_info_u               op;
        logic [XLEN-1:0]        op_a;
        logic [XLEN-1:0]        op_b;
        logic [REG_ADDR_W-1:0]  rd;
        logic [COMMIT_ID_W-1:0] commit_id;
    } exec_req_t;

    typedef struct packed {
        logic                   valid;
        logic [REG_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]        data;
        logic [COMMIT_ID_W-1:0] commit_id;
    } unit_res_t;

    // register file write port
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } wb_t;

endpackage
